/* verilog/stamofu_settings.svh */
/*
 * Build settings for the store-AMO-fence request path.
 * VPN and PO word widths must stay 20 and 10 to match 32-bit addressing.
 * The bank bit indexes the PO word, not the byte address.
 */
`ifndef STAMOFU_SETTINGS_SVH
`define STAMOFU_SETTINGS_SVH

// Depth of each launch-queue bank
`define STAMOFU_LQ_ENTRIES_PER_BANK 2

`define STAMOFU_VPN_WIDTH 20
`define STAMOFU_PO_WORD_WIDTH 10

`define STAMOFU_CQ_INDEX_WIDTH 4

// Word-offset bit that picks the dcache bank
`define STAMOFU_BANK_BIT 0

`endif

/* verilog/stamofu_pkg.sv */
/*
 * Types shared by the store-AMO-fence request path.
 * The request struct is stored as one word in the launch queue.
 */
`include "stamofu_settings.svh"

package stamofu_pkg;

    typedef enum logic [6:0] {
        OP_STORE    = 7'b0100011,
        OP_AMO      = 7'b0101111,
        OP_MISC_MEM = 7'b0001111
    } opcode_e;

    typedef enum logic [3:0] {
        AMO_LR   = 4'd0,
        AMO_SC   = 4'd1,
        AMO_SWAP = 4'd2,
        AMO_ADD  = 4'd3,
        AMO_XOR  = 4'd4,
        AMO_AND  = 4'd5,
        AMO_OR   = 4'd6,
        AMO_MIN  = 4'd7,
        AMO_MAX  = 4'd8,
        AMO_MINU = 4'd9,
        AMO_MAXU = 4'd10
    } amo_kind_e;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [4:0] funct5;
        logic       aq;
        logic       rl;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } amo_fmt_t;

    // Same instruction word seen as S-type or AMO R-type
    typedef union packed {
        s_fmt_t   s_fmt;
        amo_fmt_t amo_fmt;
    } instr_u;

    typedef struct packed {
        logic                                is_store;
        logic                                is_amo;
        logic                                is_fence;
        logic [3:0]                          op;
        logic                                is_mq;
        logic                                misaligned;
        logic                                misaligned_exception;
        logic [`STAMOFU_VPN_WIDTH-1:0]       vpn;
        logic [`STAMOFU_PO_WORD_WIDTH-1:0]   po_word;
        logic [3:0]                          byte_mask;
        logic [31:0]                         write_data;
        logic [`STAMOFU_CQ_INDEX_WIDTH-1:0]  cq_index;
    } stamofu_req_t;

endpackage

/* verilog/stamofu_req_if.sv */
/*
 * One launch request with valid/ready, decode to launch queue.
 * Source holds req steady while valid is high and ready is low.
 */
`timescale 1ns/1ns

interface stamofu_req_if import stamofu_pkg::*; ();

    logic         valid;
    logic         ready;
    stamofu_req_t req;

    modport source (
        output valid,
        output req,
        input  ready
    );

    modport sink (
        input  valid,
        input  req,
        output ready
    );

endinterface

/* verilog/q_fast_ready.sv */
/*
 * Circular FIFO. enq_ready stays high when full if the head leaves
 * in the same cycle. New entries are visible at the head one edge later.
 */
`timescale 1ns/1ns

module q_fast_ready #(
    parameter int DATA_WIDTH  = 32,
    parameter int NUM_ENTRIES = 2
) (
    input  logic                  CLK,
    input  logic                  rst_n,

    input  logic                  enq_valid,
    input  logic [DATA_WIDTH-1:0] enq_data,
    output logic                  enq_ready,

    output logic                  deq_valid,
    output logic [DATA_WIDTH-1:0] deq_data,
    input  logic                  deq_ready
);

    localparam int PTR_WIDTH   = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam int COUNT_WIDTH = $clog2(NUM_ENTRIES + 1);

    logic [DATA_WIDTH-1:0]  mem [NUM_ENTRIES];
    logic [PTR_WIDTH-1:0]   head;
    logic [PTR_WIDTH-1:0]   tail;
    logic [COUNT_WIDTH-1:0] count;
    logic                   full;
    logic                   do_enq;
    logic                   do_deq;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(NUM_ENTRIES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == COUNT_WIDTH'(NUM_ENTRIES));
    assign deq_valid = (count != '0);
    assign deq_data  = mem[head];

    // When full, deq_valid is high, so a taken head frees a slot now
    assign enq_ready = ~full | deq_ready;

    assign do_enq = enq_valid & enq_ready;
    assign do_deq = deq_valid & deq_ready;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= next_ptr(tail);
            end
            if (do_deq) begin
                head <= next_ptr(head);
            end
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (!do_enq && do_deq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (do_enq) begin
            mem[tail] <= enq_data;
        end
    end

    count_in_range: assert property (@(posedge CLK) disable iff (!rst_n)
        count <= COUNT_WIDTH'(NUM_ENTRIES));

endmodule

/* verilog/stamofu_decode.sv */
/*
 * Registered decode of store, AMO and fence into a launch request.
 * Only the first half of a misaligned store is described here.
 * Any other opcode is illegal at this point and is not decoded.
 */
`timescale 1ns/1ns
`include "stamofu_settings.svh"

module stamofu_decode import stamofu_pkg::*; (
    input  logic                               CLK,
    input  logic                               rst_n,

    input  logic                               in_valid,
    input  instr_u                             in_instr,
    input  logic [31:0]                        in_rs1,
    input  logic [31:0]                        in_rs2,
    input  logic [`STAMOFU_CQ_INDEX_WIDTH-1:0] in_cq_index,
    output logic                               in_ready,

    stamofu_req_if.source                      req_out
);

    opcode_e      opcode;
    stamofu_req_t next_req;
    stamofu_req_t req_q;
    logic         valid_q;

    function automatic amo_kind_e amo_kind(input logic [4:0] funct5);
        case (funct5)
            5'b00010: return AMO_LR;
            5'b00011: return AMO_SC;
            5'b00001: return AMO_SWAP;
            5'b00000: return AMO_ADD;
            5'b00100: return AMO_XOR;
            5'b01100: return AMO_AND;
            5'b01000: return AMO_OR;
            5'b10000: return AMO_MIN;
            5'b10100: return AMO_MAX;
            5'b11000: return AMO_MINU;
            5'b11100: return AMO_MAXU;
            default:  return AMO_ADD;
        endcase
    endfunction

    // Opcode sits in the same bits for both views
    assign opcode = opcode_e'(in_instr.s_fmt.opcode);

    always_comb begin
        logic [31:0] store_imm;
        logic [31:0] addr;
        logic [3:0]  size_mask;

        store_imm = {{20{in_instr.s_fmt.imm_hi[6]}}, in_instr.s_fmt.imm_hi,
                     in_instr.s_fmt.imm_lo};
        addr      = '0;
        size_mask = '0;
        next_req  = '0;
        next_req.cq_index = in_cq_index;

        case (opcode)
            OP_STORE: begin
                addr = in_rs1 + store_imm;
                next_req.is_store = 1'b1;
                next_req.op       = {1'b0, in_instr.s_fmt.funct3};
                case (in_instr.s_fmt.funct3[1:0])
                    2'b00: begin
                        size_mask = 4'b0001;
                    end
                    2'b01: begin
                        size_mask = 4'b0011;
                        next_req.misaligned = addr[0];
                    end
                    default: begin
                        size_mask = 4'b1111;
                        next_req.misaligned = |addr[1:0];
                    end
                endcase
                // Upper bytes of a line-crossing store drop off here
                next_req.byte_mask  = size_mask << addr[1:0];
                next_req.write_data = in_rs2 << {addr[1:0], 3'b000};
                next_req.is_mq      = next_req.misaligned;
            end
            OP_AMO: begin
                addr = in_rs1;
                next_req.is_amo               = 1'b1;
                next_req.op                   = amo_kind(in_instr.amo_fmt.funct5);
                next_req.byte_mask            = 4'b1111;
                next_req.write_data           = in_rs2;
                next_req.misaligned           = |addr[1:0];
                next_req.misaligned_exception = |addr[1:0];
            end
            OP_MISC_MEM: begin
                next_req.is_fence = 1'b1;
            end
            default: begin
                next_req.is_fence = 1'b0;
            end
        endcase

        next_req.vpn     = addr[31:12];
        next_req.po_word = addr[11:2];
    end

    // One-entry pipeline register
    assign in_ready = ~valid_q | req_out.ready;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (in_valid && in_ready) begin
            req_q <= next_req;
        end
    end

    assign req_out.valid = valid_q;
    assign req_out.req   = req_q;

    legal_opcode: assert property (@(posedge CLK) disable iff (!rst_n)
        in_valid |-> opcode inside {OP_STORE, OP_AMO, OP_MISC_MEM});

endmodule

/* verilog/stamofu_lq.sv */
/*
 * Two-bank launch queue steered by the PO word bank bit.
 * Input ready follows only the selected bank, so banks drain independently.
 */
`timescale 1ns/1ns
`include "stamofu_settings.svh"

module stamofu_lq import stamofu_pkg::*; #(
    parameter int STAMOFU_LQ_ENTRIES_PER_BANK = `STAMOFU_LQ_ENTRIES_PER_BANK
) (
    input  logic         CLK,
    input  logic         rst_n,

    stamofu_req_if.sink  req_in,

    output logic         bank0_valid,
    output stamofu_req_t bank0_req,
    input  logic         bank0_ready,

    output logic         bank1_valid,
    output stamofu_req_t bank1_req,
    input  logic         bank1_ready
);

    localparam int REQ_WIDTH = $bits(stamofu_req_t);

    logic                 bank_sel;
    logic [1:0]           enq_valid;
    logic [1:0]           enq_ready;
    logic [1:0]           deq_valid;
    logic [1:0]           deq_ready;
    logic [REQ_WIDTH-1:0] deq_data [2];

    assign bank_sel = req_in.req.po_word[`STAMOFU_BANK_BIT];

    assign enq_valid[0] = req_in.valid & ~bank_sel;
    assign enq_valid[1] = req_in.valid & bank_sel;
    assign req_in.ready = enq_ready[bank_sel];

    assign deq_ready = {bank1_ready, bank0_ready};

    for (genvar b = 0; b < 2; b++) begin : g_bank
        q_fast_ready #(
            .DATA_WIDTH(REQ_WIDTH),
            .NUM_ENTRIES(STAMOFU_LQ_ENTRIES_PER_BANK)
        ) u_q (
            .CLK(CLK),
            .rst_n(rst_n),
            .enq_valid(enq_valid[b]),
            .enq_data(req_in.req),
            .enq_ready(enq_ready[b]),
            .deq_valid(deq_valid[b]),
            .deq_data(deq_data[b]),
            .deq_ready(deq_ready[b])
        );
    end

    assign bank0_valid = deq_valid[0];
    assign bank0_req   = stamofu_req_t'(deq_data[0]);
    assign bank1_valid = deq_valid[1];
    assign bank1_req   = stamofu_req_t'(deq_data[1]);

    // Decode must hold its register while the chosen bank is full
    held_req_stable: assert property (@(posedge CLK) disable iff (!rst_n)
        req_in.valid && !req_in.ready |=> req_in.valid && $stable(req_in.req));

endmodule

/* verilog/stamofu_top.sv */
/*
 * Store-AMO-fence request path: decode stage then banked launch queue.
 * Bank requests leave flattened; each bank has its own valid/ready.
 */
`timescale 1ns/1ns
`include "stamofu_settings.svh"

module stamofu_top import stamofu_pkg::*; (
    input  logic                               CLK,
    input  logic                               rst_n,

    input  logic                               in_valid,
    input  logic [31:0]                        in_instr,
    input  logic [31:0]                        in_rs1,
    input  logic [31:0]                        in_rs2,
    input  logic [`STAMOFU_CQ_INDEX_WIDTH-1:0] in_cq_index,
    output logic                               in_ready,

    output logic                               bank0_valid,
    input  logic                               bank0_ready,
    output logic                               bank0_is_store,
    output logic                               bank0_is_amo,
    output logic                               bank0_is_fence,
    output logic [3:0]                         bank0_op,
    output logic                               bank0_is_mq,
    output logic                               bank0_misaligned,
    output logic                               bank0_misaligned_exception,
    output logic [`STAMOFU_VPN_WIDTH-1:0]      bank0_vpn,
    output logic [`STAMOFU_PO_WORD_WIDTH-1:0]  bank0_po_word,
    output logic [3:0]                         bank0_byte_mask,
    output logic [31:0]                        bank0_write_data,
    output logic [`STAMOFU_CQ_INDEX_WIDTH-1:0] bank0_cq_index,

    output logic                               bank1_valid,
    input  logic                               bank1_ready,
    output logic                               bank1_is_store,
    output logic                               bank1_is_amo,
    output logic                               bank1_is_fence,
    output logic [3:0]                         bank1_op,
    output logic                               bank1_is_mq,
    output logic                               bank1_misaligned,
    output logic                               bank1_misaligned_exception,
    output logic [`STAMOFU_VPN_WIDTH-1:0]      bank1_vpn,
    output logic [`STAMOFU_PO_WORD_WIDTH-1:0]  bank1_po_word,
    output logic [3:0]                         bank1_byte_mask,
    output logic [31:0]                        bank1_write_data,
    output logic [`STAMOFU_CQ_INDEX_WIDTH-1:0] bank1_cq_index
);

    stamofu_req_t bank0_req;
    stamofu_req_t bank1_req;

    stamofu_req_if req_if ();

    stamofu_decode u_decode (
        .CLK(CLK),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_instr(in_instr),
        .in_rs1(in_rs1),
        .in_rs2(in_rs2),
        .in_cq_index(in_cq_index),
        .in_ready(in_ready),
        .req_out(req_if.source)
    );

    stamofu_lq u_lq (
        .CLK(CLK),
        .rst_n(rst_n),
        .req_in(req_if.sink),
        .bank0_valid(bank0_valid),
        .bank0_req(bank0_req),
        .bank0_ready(bank0_ready),
        .bank1_valid(bank1_valid),
        .bank1_req(bank1_req),
        .bank1_ready(bank1_ready)
    );

    // Field order follows stamofu_req_t
    assign {bank0_is_store, bank0_is_amo, bank0_is_fence, bank0_op, bank0_is_mq,
            bank0_misaligned, bank0_misaligned_exception, bank0_vpn, bank0_po_word,
            bank0_byte_mask, bank0_write_data, bank0_cq_index} = bank0_req;

    assign {bank1_is_store, bank1_is_amo, bank1_is_fence, bank1_op, bank1_is_mq,
            bank1_misaligned, bank1_misaligned_exception, bank1_vpn, bank1_po_word,
            bank1_byte_mask, bank1_write_data, bank1_cq_index} = bank1_req;

endmodule

/* testbench/stamofu_tb.sv */
/*
 * Trace-driven testbench for stamofu_top; run from the project root.
 * Both bank readies stay low for the first cycles so bank 0 fills,
 * then follow an LCG at about 70% high.
 */
`timescale 1ns/1ns
`include "stamofu_settings.svh"

module stamofu_tb;

    localparam int CQW       = `STAMOFU_CQ_INDEX_WIDTH;
    localparam int VPNW      = `STAMOFU_VPN_WIDTH;
    localparam int POW       = `STAMOFU_PO_WORD_WIDTH;
    localparam int WD_LO     = CQW;
    localparam int MASK_LO   = WD_LO + 32;
    localparam int PO_LO     = MASK_LO + 4;
    localparam int VPN_LO    = PO_LO + POW;
    localparam int FLAG_LO   = VPN_LO + VPNW;
    localparam int EXP_W     = FLAG_LO + 10;
    localparam int MAX_LINES = 64;
    localparam int STALL_NEGEDGES = 16;

    logic            CLK;
    logic            rst_n;
    logic            in_valid;
    logic [31:0]     in_instr;
    logic [31:0]     in_rs1;
    logic [31:0]     in_rs2;
    logic [CQW-1:0]  in_cq_index;
    logic            in_ready;

    logic            bank0_valid, bank0_ready, bank0_is_store, bank0_is_amo, bank0_is_fence;
    logic            bank0_is_mq, bank0_misaligned, bank0_misaligned_exception;
    logic [3:0]      bank0_op, bank0_byte_mask;
    logic [VPNW-1:0] bank0_vpn;
    logic [POW-1:0]  bank0_po_word;
    logic [31:0]     bank0_write_data;
    logic [CQW-1:0]  bank0_cq_index;

    logic            bank1_valid, bank1_ready, bank1_is_store, bank1_is_amo, bank1_is_fence;
    logic            bank1_is_mq, bank1_misaligned, bank1_misaligned_exception;
    logic [3:0]      bank1_op, bank1_byte_mask;
    logic [VPNW-1:0] bank1_vpn;
    logic [POW-1:0]  bank1_po_word;
    logic [31:0]     bank1_write_data;
    logic [CQW-1:0]  bank1_cq_index;

    logic [EXP_W-1:0] act0;
    logic [EXP_W-1:0] act1;
    logic [EXP_W-1:0] exp_q0[$];
    logic [EXP_W-1:0] exp_q1[$];
    int               entry_q0[$];
    int               entry_q1[$];
    logic [31:0]      tr_instr [MAX_LINES];
    logic [31:0]      tr_rs1 [MAX_LINES];
    logic [31:0]      tr_rs2 [MAX_LINES];
    logic [CQW-1:0]   tr_cq [MAX_LINES];
    logic [31:0]      f [16];
    logic [31:0]      rand_state;
    int               num_lines;
    int               limit_cycles;
    int               mismatches;
    int               failures;
    int               stall_cycles;
    int               neg_count;

    stamofu_top UUT (.*);

    assign act0 = {bank0_is_store, bank0_is_amo, bank0_is_fence, bank0_op, bank0_is_mq,
                   bank0_misaligned, bank0_misaligned_exception, bank0_vpn, bank0_po_word,
                   bank0_byte_mask, bank0_write_data, bank0_cq_index};
    assign act1 = {bank1_is_store, bank1_is_amo, bank1_is_fence, bank1_op, bank1_is_mq,
                   bank1_misaligned, bank1_misaligned_exception, bank1_vpn, bank1_po_word,
                   bank1_byte_mask, bank1_write_data, bank1_cq_index};

    always #20 CLK = ~CLK;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Pops the oldest expected request of a bank and compares it field group by group
    task automatic check_entry(input int b, input logic [EXP_W-1:0] act);
        logic [EXP_W-1:0] exp;
        int               entry;
        string            tag;
        if ((b == 0 && exp_q0.size() == 0) || (b == 1 && exp_q1.size() == 0)) begin
            failures++;
            $display("Bank %0d sent a request that the trace does not hold", b);
            return;
        end
        if (b == 0) begin
            exp   = exp_q0.pop_front();
            entry = entry_q0.pop_front();
        end else begin
            exp   = exp_q1.pop_front();
            entry = entry_q1.pop_front();
        end
        tag = $sformatf("entry%0d_bank%0d", entry, b);
        check_value({tag, " flags"}, exp[FLAG_LO +: 10], act[FLAG_LO +: 10]);
        check_value({tag, " vpn"}, exp[VPN_LO +: VPNW], act[VPN_LO +: VPNW]);
        check_value({tag, " po_word"}, exp[PO_LO +: POW], act[PO_LO +: POW]);
        check_value({tag, " byte_mask"}, exp[MASK_LO +: 4], act[MASK_LO +: 4]);
        check_value({tag, " write_data"}, exp[WD_LO +: 32], act[WD_LO +: 32]);
        check_value({tag, " cq_index"}, exp[CQW-1:0], act[CQW-1:0]);
    endtask

    task automatic finish_run();
        $display("Run done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    always @(negedge CLK) begin
        neg_count++;
        if (neg_count < STALL_NEGEDGES) begin
            bank0_ready = 1'b0;
            bank1_ready = 1'b0;
        end else begin
            rand_state  = lcg_step(rand_state);
            bank0_ready = (rand_state[30:16] % 100) < 70;
            rand_state  = lcg_step(rand_state);
            bank1_ready = (rand_state[30:16] % 100) < 70;
        end
    end

    always @(posedge CLK) begin
        if (rst_n) begin
            if (bank0_valid && bank0_ready) check_entry(0, act0);
            if (bank1_valid && bank1_ready) check_entry(1, act1);
            if (in_valid && !in_ready) stall_cycles++;
        end
    end

    initial begin
        int               fd;
        int               n;
        int               code;
        string            text;
        logic [EXP_W-1:0] expv;
        CLK = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_cq_index = '0;
        bank0_ready = 1'b0;
        bank1_ready = 1'b0;
        rand_state = 32'd79489;
        mismatches = 0;
        failures = 0;
        stall_cycles = 0;
        neg_count = 0;
        num_lines = 0;

        fd = $fopen("testbench/stamofu_trace.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Cannot open the trace file testbench/stamofu_trace.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            text = "";
            code = $fgets(text, fd);
            if (code == 0 || text.len() < 2 || text[0] == "#") continue;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
            if (n != 16 || num_lines >= MAX_LINES) begin
                failures++;
                $display("Trace line could not be read: %s", text);
                continue;
            end
            tr_instr[num_lines] = f[0];
            tr_rs1[num_lines]   = f[1];
            tr_rs2[num_lines]   = f[2];
            tr_cq[num_lines]    = f[3][CQW-1:0];
            expv = {f[5][0], f[6][0], f[7][0], f[8][3:0], f[9][0], f[10][0], f[11][0],
                    f[12][VPNW-1:0], f[13][POW-1:0], f[14][3:0], f[15], f[3][CQW-1:0]};
            if (f[4][0]) begin
                exp_q1.push_back(expv);
                entry_q1.push_back(num_lines + 1);
            end else begin
                exp_q0.push_back(expv);
                entry_q0.push_back(num_lines + 1);
            end
            num_lines++;
        end
        if (fd != 0) $fclose(fd);
        limit_cycles = num_lines * 200 + 100;

        repeat (2) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge CLK);
            check_value("reset in_ready", 32'd1, in_ready);
            check_value("reset bank0_valid", 32'd0, bank0_valid);
            check_value("reset bank1_valid", 32'd0, bank1_valid);
        end

        for (int i = 0; i < num_lines; i++) begin
            @(negedge CLK);
            in_valid    = 1'b1;
            in_instr    = tr_instr[i];
            in_rs1      = tr_rs1[i];
            in_rs2      = tr_rs2[i];
            in_cq_index = tr_cq[i];
            @(posedge CLK);
            while (!in_ready) @(posedge CLK);
        end
        @(negedge CLK);
        in_valid = 1'b0;

        while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge CLK);
        // A few idle cycles catch duplicated requests
        repeat (4) @(posedge CLK);
        if (num_lines == 0) begin
            failures++;
            $display("The trace holds no instructions");
        end else if (stall_cycles == 0) begin
            failures++;
            $display("in_ready never fell while a bank was full");
        end
        finish_run();
    end

    initial begin
        #1;
        repeat (limit_cycles) @(posedge CLK);
        failures++;
        $display("Timeout after %0d cycles with %0d requests still queued",
                 limit_cycles, exp_q0.size() + exp_q1.size());
        finish_run();
    end

endmodule

/* src.f */
+incdir+verilog
verilog/stamofu_pkg.sv
verilog/stamofu_req_if.sv
verilog/q_fast_ready.sv
verilog/stamofu_decode.sv
verilog/stamofu_lq.sv
verilog/stamofu_top.sv
testbench/stamofu_tb.sv

/* testbench/stamofu_trace.txt */
# instr rs1 rs2 cq_index bank | is_store is_amo is_fence op is_mq misaligned mis_exception
# vpn po_word byte_mask write_data (all hex, one instruction per line)
00208023 12345000 a1b2c3d4 0 0 1 0 0 0 0 0 0 12345 000 1 a1b2c3d4
00208023 12345001 a1b2c3d4 1 0 1 0 0 0 0 0 0 12345 000 2 b2c3d400
00208023 12345002 a1b2c3d4 2 0 1 0 0 0 0 0 0 12345 000 4 c3d40000
00208023 12345003 a1b2c3d4 3 0 1 0 0 0 0 0 0 12345 000 8 d4000000
00209023 12345004 a1b2c3d4 4 1 1 0 0 1 0 0 0 12345 001 3 a1b2c3d4
00209023 12345005 a1b2c3d4 5 1 1 0 0 1 1 1 0 12345 001 6 b2c3d400
00209023 12345006 a1b2c3d4 6 1 1 0 0 1 0 0 0 12345 001 c c3d40000
00209023 12345007 a1b2c3d4 7 1 1 0 0 1 1 1 0 12345 001 8 d4000000
0020a023 12345008 a1b2c3d4 8 0 1 0 0 2 0 0 0 12345 002 f a1b2c3d4
0020a023 12345009 a1b2c3d4 9 0 1 0 0 2 1 1 0 12345 002 e b2c3d400
0020a023 1234500a a1b2c3d4 a 0 1 0 0 2 1 1 0 12345 002 c c3d40000
0020a023 1234500b a1b2c3d4 b 0 1 0 0 2 1 1 0 12345 002 8 d4000000
0020a223 0000fffc a1b2c3d4 c 0 1 0 0 2 0 0 0 00010 000 f a1b2c3d4
fe208fa3 80000000 a1b2c3d4 d 1 1 0 0 0 0 0 0 7ffff 3ff 8 d4000000
fe20ac23 00003014 a1b2c3d4 e 1 1 0 0 2 0 0 0 00003 003 f a1b2c3d4
0020a1af 20000010 55aa00ff f 0 0 1 0 3 0 0 0 20000 004 f 55aa00ff
0820a1af 20000014 55aa00ff 0 1 0 1 0 2 0 0 0 20000 005 f 55aa00ff
1020a1af 20000018 55aa00ff 1 0 0 1 0 0 0 0 0 20000 006 f 55aa00ff
1820a1af 2000001c 55aa00ff 2 1 0 1 0 1 0 0 0 20000 007 f 55aa00ff
2020a1af 20000020 55aa00ff 3 0 0 1 0 4 0 0 0 20000 008 f 55aa00ff
4020a1af 20000024 55aa00ff 4 1 0 1 0 6 0 0 0 20000 009 f 55aa00ff
6020a1af 20000028 55aa00ff 5 0 0 1 0 5 0 0 0 20000 00a f 55aa00ff
8020a1af 2000002c 55aa00ff 6 1 0 1 0 7 0 0 0 20000 00b f 55aa00ff
a020a1af 20000030 55aa00ff 7 0 0 1 0 8 0 0 0 20000 00c f 55aa00ff
c020a1af 20000034 55aa00ff 8 1 0 1 0 9 0 0 0 20000 00d f 55aa00ff
e020a1af 20000038 55aa00ff 9 0 0 1 0 a 0 0 0 20000 00e f 55aa00ff
0020a1af 20000042 55aa00ff a 0 0 1 0 3 0 1 1 20000 010 f 55aa00ff
0820a1af 20000045 55aa00ff b 1 0 1 0 2 0 1 1 20000 011 f 55aa00ff
0ff0000f deadbeef deadbeef c 0 0 0 1 0 0 0 0 00000 000 0 00000000
0020a023 00001100 0b000001 d 0 1 0 0 2 0 0 0 00001 040 f 0b000001
0020a023 00001108 0b000002 e 0 1 0 0 2 0 0 0 00001 042 f 0b000002
0020a023 00001110 0b000003 f 0 1 0 0 2 0 0 0 00001 044 f 0b000003
0020a023 00001118 0b000004 0 0 1 0 0 2 0 0 0 00001 046 f 0b000004
0020a023 00001104 0b000005 1 1 1 0 0 2 0 0 0 00001 041 f 0b000005
0020a023 0000110c 0b000006 2 1 1 0 0 2 0 0 0 00001 043 f 0b000006
0020a023 00001114 0b000007 3 1 1 0 0 2 0 0 0 00001 045 f 0b000007
